// File: Makefile
# Verilator flow for the processing element

TB  := pe_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module pe_top

# the run passes only if the log holds the pass line
sim:
	verilator --binary --timing --assert -f project.f --top-module $(TB) -o $(TB)_sim
	./obj_dir/$(TB)_sim | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/pe_tb.sv
`timescale 1ns/100ps
`include "pe_cfg.svh"

module pe_tb;

    localparam int TABLE_LEN      = 32;
    localparam int RUN2_START     = 21;
    localparam int TIMEOUT_CYCLES = TABLE_LEN + 20;

    typedef struct packed {
        logic                        in_valid;
        pe_data_pkg::weight_entry_t  weight;
        pe_data_pkg::feature_group_t feature;
    } stim_row_t;

    logic                        clk;
    logic                        rst;
    logic                        in_valid;
    pe_data_pkg::weight_entry_t  weight_in;
    pe_data_pkg::feature_group_t feature_in;
    pe_ctrl_pkg::count_t         weight_total;
    pe_ctrl_pkg::count_t         feature_total;
    pe_data_pkg::result_block_t  result;
    logic                        out_valid;
    pe_ctrl_pkg::count_t         weight_count;
    logic                        done;

    // stimulus rows and what the model expects after each row's edge
    stim_row_t                  stim       [TABLE_LEN];
    logic                       exp_accept [TABLE_LEN];
    pe_data_pkg::result_block_t exp_block  [TABLE_LEN];
    pe_ctrl_pkg::count_t        exp_count  [TABLE_LEN];
    logic                       exp_done   [TABLE_LEN];

    pe_data_pkg::weight_bank_t    m_bank;
    pe_data_pkg::feature_window_t m_window;
    int                           m_cycle;
    pe_ctrl_pkg::count_t          m_count;
    logic                         m_done;

    logic [31:0] lcg_state;
    int          cycle_cnt = 0;
    int          first_row;
    int          last_row;

    pe_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .weight_in     (weight_in),
        .feature_in    (feature_in),
        .weight_total  (weight_total),
        .feature_total (feature_total),
        .result        (result),
        .out_valid     (out_valid),
        .weight_count  (weight_count),
        .done          (done)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // counts cycles out of reset only
    always @(posedge clk) begin
        if (!rst) begin
            cycle_cnt <= cycle_cnt + 1;
        end
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [7:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    function automatic pe_ctrl_pkg::count_t run_weights(input int run);
        return (run == 0) ? pe_ctrl_pkg::count_t'(8) : pe_ctrl_pkg::count_t'(4);
    endfunction

    function automatic pe_ctrl_pkg::count_t run_features(input int run);
        return (run == 0) ? pe_ctrl_pkg::count_t'(6) : pe_ctrl_pkg::count_t'(4);
    endfunction

    function automatic pe_data_pkg::result_block_t expect_block(
        input pe_data_pkg::weight_bank_t    bank,
        input pe_data_pkg::feature_window_t win
    );
        pe_data_pkg::result_block_t blk;
        int wv;
        int pv;
        int prod;
        int diff;
        for (int i = 0; i < `PE_LANES; i++) begin
            for (int j = 0; j < `PE_LANES; j++) begin
                wv   = {{24{bank[i].value[7]}}, bank[i].value};
                pv   = {{24{win[i][j].value[7]}}, win[i][j].value};
                prod = wv * pv;
                blk[i*`PE_LANES + j].product = prod[15:0];
                diff = int'(win[i][j].row) - int'(bank[i].row);
                blk[i*`PE_LANES + j].row_off = diff[7:0];
                diff = int'(win[i][j].col) - int'(bank[i].col);
                blk[i*`PE_LANES + j].col_off = diff[7:0];
            end
        end
        return blk;
    endfunction

    task automatic model_reset();
        m_bank   = '0;
        m_window = '0;
        m_cycle  = 0;
        m_count  = '0;
        m_done   = 1'b0;
    endtask

    task automatic model_step(
        input  stim_row_t           row,
        input  pe_ctrl_pkg::count_t wt,
        input  pe_ctrl_pkg::count_t ft,
        output logic                accepted
    );
        accepted = row.in_valid && !m_done;
        if (accepted) begin
            // first four accepted cycles of a batch fill the slots
            if (m_cycle < `PE_LANES) begin
                m_bank[m_cycle] = row.weight;
                m_count         = m_count + 1'b1;
            end
            for (int k = `PE_LANES - 1; k > 0; k--) begin
                m_window[k] = m_window[k-1];
            end
            m_window[0] = row.feature;
            if (m_cycle == int'(ft) - 1) begin
                m_cycle = 0;
                if (m_count == wt) begin
                    m_done = 1'b1;
                end
            end else begin
                m_cycle++;
            end
        end
    endtask

    task automatic fill_table();
        stim_row_t row;
        for (int r = 0; r < TABLE_LEN; r++) begin
            // gaps mid-batch, then strobes after done, then idle drain rows
            row.in_valid     = !(r inside {2, 8, 18, 19, 20, 26, 29, 30, 31});
            row.weight.value = next_rand();
            row.weight.row   = next_rand();
            row.weight.col   = next_rand();
            for (int j = 0; j < `PE_LANES; j++) begin
                row.feature[j].value = next_rand();
                row.feature[j].row   = next_rand();
                row.feature[j].col   = next_rand();
            end
            stim[r] = row;
        end
        // extremes so products go negative and offsets wrap
        stim[1].weight.value     = 8'h7f;
        stim[1].weight.row       = 8'h81;
        stim[4].feature[0].value = 8'h80;
        stim[4].feature[0].row   = 8'h7f;
        stim[5].feature[1].col   = 8'h80;
    endtask

    task automatic build_expected();
        int run;
        for (int r = 0; r < TABLE_LEN; r++) begin
            run = (r < RUN2_START) ? 0 : 1;
            if (r == 0 || r == RUN2_START) begin
                model_reset();
            end
            model_step(stim[r], run_weights(run), run_features(run), exp_accept[r]);
            exp_block[r] = expect_block(m_bank, m_window);
            exp_count[r] = m_count;
            exp_done[r]  = m_done;
        end
    endtask

    task automatic check_result(
        input string                      name,
        input pe_data_pkg::result_block_t got,
        input pe_data_pkg::result_block_t exp
    );
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "result block mismatch");
        end
    endtask

    task automatic check_count(
        input string               name,
        input pe_ctrl_pkg::count_t got,
        input pe_ctrl_pkg::count_t exp
    );
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    // counters follow one edge behind a row, results two edges behind
    task automatic check_outputs(input int r, input int start);
        if (r - 1 >= start) begin
            check_count("weight_count", weight_count, exp_count[r-1]);
            check_flag("done", done, exp_done[r-1]);
        end else begin
            check_count("weight_count", weight_count, '0);
            check_flag("done", done, 1'b0);
        end
        if (r - 2 >= start) begin
            check_flag("out_valid", out_valid, exp_accept[r-2]);
            if (exp_accept[r-2]) begin
                check_result("result", result, exp_block[r-2]);
            end
        end else begin
            check_flag("out_valid", out_valid, 1'b0);
        end
    endtask

    task automatic apply_reset(input pe_ctrl_pkg::count_t wt, input pe_ctrl_pkg::count_t ft);
        @(negedge clk);
        rst           = 1'b1;
        in_valid      = 1'b0;
        weight_total  = wt;
        feature_total = ft;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    endtask

    initial begin
        lcg_state     = 32'd85148;
        rst           = 1'b1;
        in_valid      = 1'b0;
        weight_in     = '0;
        feature_in    = '0;
        weight_total  = run_weights(0);
        feature_total = run_features(0);
        fill_table();
        build_expected();

        for (int run = 0; run < 2; run++) begin
            first_row = (run == 0) ? 0 : RUN2_START;
            last_row  = (run == 0) ? RUN2_START : TABLE_LEN;
            apply_reset(run_weights(run), run_features(run));
            check_flag("out_valid", out_valid, 1'b0);
            check_flag("done", done, 1'b0);
            check_count("weight_count", weight_count, '0);
            for (int r = first_row; r < last_row; r++) begin
                @(negedge clk);
                check_outputs(r, first_row);
                in_valid   = stim[r].in_valid;
                weight_in  = stim[r].weight;
                feature_in = stim[r].feature;
            end
        end

        $display("Test OK");
        $finish;
    end

endmodule

// File: logic/batch_sequencer.sv
`timescale 1ns/100ps
`include "pe_cfg.svh"

module batch_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  pe_ctrl_pkg::count_t weight_total,
    input  pe_ctrl_pkg::count_t feature_total,
    output logic                weight_we,
    output pe_ctrl_pkg::slot_t  weight_slot,
    output logic                feature_shift,
    output pe_ctrl_pkg::count_t weight_count,
    output logic                done
);

    pe_ctrl_pkg::seq_state_t state;
    pe_ctrl_pkg::seq_state_t state_nxt;
    pe_ctrl_pkg::count_t     cycle_cnt;
    pe_ctrl_pkg::count_t     cycle_cnt_nxt;
    pe_ctrl_pkg::count_t     weight_count_nxt;
    logic                    accept;
    logic                    batch_end;
    logic                    load_last;

    // nothing is taken once the element is done
    assign accept        = in_valid && (state != pe_ctrl_pkg::DONE);
    assign feature_shift = accept;
    assign weight_we     = accept && (state == pe_ctrl_pkg::LOAD_WEIGHT);
    assign weight_slot   = cycle_cnt[`PE_SLOT_W-1:0];

    assign batch_end = accept && (cycle_cnt == feature_total - 1'b1);
    assign load_last = cycle_cnt == pe_ctrl_pkg::count_t'(`PE_LANES - 1);

    // includes a weight written on the batch's last cycle
    assign weight_count_nxt = weight_count + pe_ctrl_pkg::count_t'(weight_we);

    assign done = (state == pe_ctrl_pkg::DONE);

    always_comb begin
        state_nxt     = state;
        cycle_cnt_nxt = cycle_cnt;
        case (state)
            pe_ctrl_pkg::LOAD_WEIGHT,
            pe_ctrl_pkg::STREAM: begin
                if (batch_end) begin
                    cycle_cnt_nxt = '0;
                    if (weight_count_nxt == weight_total) begin
                        state_nxt = pe_ctrl_pkg::DONE;
                    end else begin
                        state_nxt = pe_ctrl_pkg::LOAD_WEIGHT;
                    end
                end else if (accept) begin
                    cycle_cnt_nxt = cycle_cnt + 1'b1;
                    if (state == pe_ctrl_pkg::LOAD_WEIGHT && load_last) begin
                        state_nxt = pe_ctrl_pkg::STREAM;
                    end
                end
            end
            default: begin
                // held until reset
                state_nxt = pe_ctrl_pkg::DONE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= pe_ctrl_pkg::LOAD_WEIGHT;
            cycle_cnt    <= '0;
            weight_count <= '0;
        end else begin
            state        <= state_nxt;
            cycle_cnt    <= cycle_cnt_nxt;
            weight_count <= weight_count_nxt;
        end
    end

    // batches load whole banks, so the total must land on a bank boundary
    a_weight_total_ok: assert property (
        @(posedge clk) disable iff (rst)
        !done |-> (weight_total != '0) && (weight_total % `PE_LANES == 0)
    );

    // a batch needs room for all slot writes
    a_feature_total_ok: assert property (
        @(posedge clk) disable iff (rst)
        feature_total >= pe_ctrl_pkg::count_t'(`PE_LANES)
    );

endmodule

// File: logic/operand_store.sv
`timescale 1ns/100ps
`include "pe_cfg.svh"

module operand_store (
    input  logic                         clk,
    input  logic                         rst,
    input  pe_data_pkg::weight_entry_t   weight_in,
    input  pe_data_pkg::feature_group_t  feature_in,
    input  logic                         weight_we,
    input  pe_ctrl_pkg::slot_t           weight_slot,
    input  logic                         feature_shift,
    output pe_data_pkg::weight_bank_t    weight_bank,
    output pe_data_pkg::feature_window_t feature_window
);

    // one slot per write, others keep their weight
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            weight_bank <= '0;
        end else if (weight_we) begin
            weight_bank[weight_slot] <= weight_in;
        end
    end

    // new group enters at 0, oldest falls off the top
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            feature_window <= '0;
        end else if (feature_shift) begin
            for (int k = `PE_LANES - 1; k > 0; k--) begin
                feature_window[k] <= feature_window[k-1];
            end
            feature_window[0] <= feature_in;
        end
    end

    // a weight only arrives together with its feature group
    a_we_with_shift: assert property (
        @(posedge clk) disable iff (rst)
        weight_we |-> feature_shift
    );

endmodule

// File: logic/pe_array.sv
`timescale 1ns/100ps
`include "pe_cfg.svh"

module pe_array (
    input  logic                         clk,
    input  logic                         rst,
    input  pe_data_pkg::weight_bank_t    weight_bank,
    input  pe_data_pkg::feature_window_t feature_window,
    input  logic                         feature_shift,
    output pe_data_pkg::result_block_t   result,
    output logic                         out_valid
);

    pe_data_pkg::result_block_t block_nxt;
    logic                       compute_en;

    // lane i pairs weight slot i with the group from i shifts back
    always_comb begin
        for (int i = 0; i < `PE_LANES; i++) begin
            for (int j = 0; j < `PE_LANES; j++) begin
                block_nxt[i*`PE_LANES + j].product =
                    weight_bank[i].value * feature_window[i][j].value;
                // offsets wrap at coordinate width
                block_nxt[i*`PE_LANES + j].row_off =
                    feature_window[i][j].row - weight_bank[i].row;
                block_nxt[i*`PE_LANES + j].col_off =
                    feature_window[i][j].col - weight_bank[i].col;
            end
        end
    end

    // store has just been updated when this is high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            compute_en <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            compute_en <= feature_shift;
            out_valid  <= compute_en;
        end
    end

    always_ff @(posedge clk) begin
        if (compute_en) begin
            result <= block_nxt;
        end
    end

    // store reset must reach every lane before the first result
    a_result_known: assert property (
        @(posedge clk) disable iff (rst)
        out_valid |-> !$isunknown(result)
    );

endmodule

// File: logic/pe_cfg.svh
`ifndef PE_CFG_SVH
`define PE_CFG_SVH

// value width for weights and pixels
`define PE_WORD_W 8

// product of two values
`define PE_PROD_W (2 * `PE_WORD_W)

// row and col coordinates
`define PE_COORD_W 8

// configuration inputs and counters
`define PE_COUNT_W 16

// weight slots per batch, also pixels per feature group
`define PE_LANES 4

// slot index width
`define PE_SLOT_W $clog2(`PE_LANES)

`endif

// File: logic/pe_ctrl_pkg.sv
`include "pe_cfg.svh"

package pe_ctrl_pkg;

    // LOAD_WEIGHT covers the first PE_LANES accepted cycles of a batch
    typedef enum logic [1:0] {
        LOAD_WEIGHT,
        STREAM,
        DONE
    } seq_state_t;

    typedef logic [`PE_COUNT_W-1:0] count_t;

    typedef logic [`PE_SLOT_W-1:0] slot_t;

endpackage

// File: logic/pe_data_pkg.sv
`include "pe_cfg.svh"

package pe_data_pkg;

    typedef logic signed [`PE_WORD_W-1:0]  word_t;
    typedef logic signed [`PE_PROD_W-1:0]  product_t;
    typedef logic signed [`PE_COORD_W-1:0] coord_t;

    // one sparse weight with its kernel position
    typedef struct packed {
        word_t  value;
        coord_t row;
        coord_t col;
    } weight_entry_t;

    typedef struct packed {
        word_t  value;
        coord_t row;
        coord_t col;
    } pixel_t;

    typedef pixel_t        [`PE_LANES-1:0] feature_group_t;
    typedef weight_entry_t [`PE_LANES-1:0] weight_bank_t;

    // index 0 holds the newest group
    typedef feature_group_t [`PE_LANES-1:0] feature_window_t;

    typedef struct packed {
        product_t product;
        coord_t   row_off;
        coord_t   col_off;
    } result_entry_t;

    // entry index is lane * PE_LANES + pixel
    typedef result_entry_t [`PE_LANES*`PE_LANES-1:0] result_block_t;

endpackage

// File: logic/pe_top.sv
`timescale 1ns/100ps

module pe_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  pe_data_pkg::weight_entry_t  weight_in,
    input  pe_data_pkg::feature_group_t feature_in,
    input  pe_ctrl_pkg::count_t         weight_total,
    input  pe_ctrl_pkg::count_t         feature_total,
    output pe_data_pkg::result_block_t  result,
    output logic                        out_valid,
    output pe_ctrl_pkg::count_t         weight_count,
    output logic                        done
);

    logic                         weight_we;
    pe_ctrl_pkg::slot_t           weight_slot;
    logic                         feature_shift;
    pe_data_pkg::weight_bank_t    weight_bank;
    pe_data_pkg::feature_window_t feature_window;

    batch_sequencer u_seq (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .weight_total  (weight_total),
        .feature_total (feature_total),
        .weight_we     (weight_we),
        .weight_slot   (weight_slot),
        .feature_shift (feature_shift),
        .weight_count  (weight_count),
        .done          (done)
    );

    operand_store u_store (
        .clk            (clk),
        .rst            (rst),
        .weight_in      (weight_in),
        .feature_in     (feature_in),
        .weight_we      (weight_we),
        .weight_slot    (weight_slot),
        .feature_shift  (feature_shift),
        .weight_bank    (weight_bank),
        .feature_window (feature_window)
    );

    pe_array u_array (
        .clk            (clk),
        .rst            (rst),
        .weight_bank    (weight_bank),
        .feature_window (feature_window),
        .feature_shift  (feature_shift),
        .result         (result),
        .out_valid      (out_valid)
    );

endmodule

// File: project.f
+incdir+logic
logic/pe_data_pkg.sv
logic/pe_ctrl_pkg.sv
logic/batch_sequencer.sv
logic/operand_store.sv
logic/pe_array.sv
logic/pe_top.sv
bench/pe_tb.sv
